// File: verilog/common_pkg.sv
package common;

// basic data and address word
typedef logic [31:0] word_t;

// architectural register index
typedef logic [4:0] regaddr_t;

// number of integer registers, x0 included
localparam int NUM_REGS = 32;

// pc carried by a bubble, a stage holding it is empty
localparam word_t NOP_PC = 32'hffff_ffff;

endpackage

// File: verilog/cpu_common_pkg.sv
package cpu_common;

// major opcode field, ir[6:0]
typedef logic [6:0] opcode_t;

localparam opcode_t OPC_LOAD   = 7'b000_0011;
localparam opcode_t OPC_STORE  = 7'b010_0011;
localparam opcode_t OPC_OP     = 7'b011_0011;
localparam opcode_t OPC_OP_IMM = 7'b001_0011;
localparam opcode_t OPC_LUI    = 7'b011_0111;
localparam opcode_t OPC_AUIPC  = 7'b001_0111;
localparam opcode_t OPC_JAL    = 7'b110_1111;
localparam opcode_t OPC_JALR   = 7'b110_0111;

// memory access size, same encoding as funct3 of loads and stores
typedef enum logic [2:0] {
    MA_SIZE_B  = 3'd0,
    MA_SIZE_H  = 3'd1,
    MA_SIZE_W  = 3'd2,
    MA_SIZE_BU = 3'd4,
    MA_SIZE_HU = 3'd5
} ma_size_t;

// data memory geometry
localparam int DMEM_WORDS = 256;
localparam int DMEM_IDX_W = $clog2(DMEM_WORDS); // word index bits, taken from addr[9:2]

endpackage

// File: verilog/cpu_mem_ctrl.sv
`timescale 1ns/1ps

module cpu_mem_ctrl (
        input  logic              clk_i,
        input  logic              rst_i,
        input  logic              issue_i,        // one retiring instruction this cycle
        input  common::word_t     pc_i,
        input  common::word_t     ir_i,
        input  common::word_t     addr_i,         // effective address
        input  common::word_t     store_data_i,
        input  common::word_t     alu_result_i,

        output common::word_t     dmem_addr_o,
        output common::word_t     dmem_wdata_o,
        output logic [3:0]        dmem_we_o,      // byte lane mask

        output common::word_t     wb_pc_o,
        output common::word_t     wb_ir_o,
        output common::word_t     wb_alu_data_o,
        output logic              wb_load_o,
        output logic              wb_en_o,
        output cpu_common::ma_size_t wb_ma_size_o,
        output logic [1:0]        wb_align_o
    );

import common::*;
import cpu_common::*;

opcode_t    opcode;
logic       dec_load;
logic       dec_store;
logic       dec_rd_write;
ma_size_t   dec_size;

// memory stage register
word_t      mem_pc;
word_t      mem_ir;
word_t      mem_addr;
word_t      mem_store_data;
word_t      mem_alu;
ma_size_t   mem_size;
logic       mem_load;
logic       mem_store;
logic       mem_rd_write;

always_comb begin
    opcode    = ir_i[6:0];
    dec_load  = (opcode == OPC_LOAD);
    // only SB, SH and SW count as stores
    dec_store = (opcode == OPC_STORE) && (ir_i[14:12] inside {3'd0, 3'd1, 3'd2});

    case (opcode)
        OPC_LOAD, OPC_OP, OPC_OP_IMM, OPC_LUI,
        OPC_AUIPC, OPC_JAL, OPC_JALR: dec_rd_write = 1'b1;
        default:                      dec_rd_write = 1'b0;
    endcase

    case (ir_i[14:12])
        3'd0:    dec_size = MA_SIZE_B;
        3'd1:    dec_size = MA_SIZE_H;
        3'd4:    dec_size = MA_SIZE_BU;
        3'd5:    dec_size = MA_SIZE_HU;
        default: dec_size = MA_SIZE_W;  // word, and reserved codes
    endcase
end

// control bits, a bubble on idle cycles
always_ff @(posedge clk_i) begin
    if (rst_i) begin
        mem_pc       <= NOP_PC;
        mem_load     <= 1'b0;
        mem_store    <= 1'b0;
        mem_rd_write <= 1'b0;
        wb_pc_o      <= NOP_PC;
        wb_load_o    <= 1'b0;
        wb_en_o      <= 1'b0;
    end else begin
        mem_pc       <= issue_i ? pc_i : NOP_PC;
        mem_load     <= issue_i && dec_load;
        mem_store    <= issue_i && dec_store;
        mem_rd_write <= issue_i && dec_rd_write;
        wb_pc_o      <= mem_pc;
        wb_load_o    <= mem_load;
        wb_en_o      <= mem_rd_write;
    end
end

// payload, don't care while a bubble passes
always_ff @(posedge clk_i) begin
    mem_ir         <= ir_i;
    mem_addr       <= addr_i;
    mem_store_data <= store_data_i;
    mem_alu        <= alu_result_i;
    mem_size       <= dec_size;

    wb_ir_o        <= mem_ir;
    wb_alu_data_o  <= mem_alu;
    wb_ma_size_o   <= mem_load ? mem_size : MA_SIZE_W;    // alu data passes unchanged
    wb_align_o     <= mem_load ? mem_addr[1:0] : 2'b00;
end

// lane mask and replicated store data
always_comb begin
    dmem_addr_o  = mem_addr;
    dmem_we_o    = 4'b0000;
    dmem_wdata_o = mem_store_data;
    if (mem_store) begin
        case (mem_size)
            MA_SIZE_B: begin
                dmem_we_o    = 4'b0001 << mem_addr[1:0];
                dmem_wdata_o = {4{mem_store_data[7:0]}};
            end
            MA_SIZE_H: begin
                dmem_we_o    = mem_addr[1] ? 4'b1100 : 4'b0011;
                dmem_wdata_o = {2{mem_store_data[15:0]}};
            end
            MA_SIZE_W: dmem_we_o = 4'b1111;
            default:   dmem_we_o = 4'b0000;
        endcase
    end
end

endmodule

// File: verilog/cpu_dmem.sv
`timescale 1ns/1ps

module cpu_dmem (
        input  logic          clk_i,
        input  common::word_t addr_i,     // byte address, low two bits ignored
        input  common::word_t wdata_i,    // lanes already replicated
        input  logic [3:0]    we_i,       // one enable per byte lane
        output common::word_t rdata_o
    );

import common::*;
import cpu_common::*;

word_t                 mem [DMEM_WORDS];
logic [DMEM_IDX_W-1:0] idx;

// upper address bits wrap onto the same words
assign idx = addr_i[DMEM_IDX_W+1:2];

always_ff @(posedge clk_i) begin
    for (int lane = 0; lane < 4; lane++) begin
        if (we_i[lane]) begin
            mem[idx][8*lane +: 8] <= wdata_i[8*lane +: 8];
        end
    end
    rdata_o <= mem[idx];    // read before write
end

endmodule

// File: verilog/cpu_wb.sv
`timescale 1ns/1ps

module cpu_wb (
        input  common::word_t        dmem_read_data_i, // registered memory word
        input  common::word_t        pc_i,
        input  common::word_t        ir_i,
        input  common::word_t        wb_data_i,        // alu result
        input  logic                 load_i,
        input  logic                 wb_valid_i,
        input  cpu_common::ma_size_t ma_size_i,
        input  logic [1:0]           ma_alignment_i,   // byte offset of the access
        output common::regaddr_t     wb_addr_o,
        output common::word_t        wb_data_o,
        output logic                 wb_valid_o,
        output logic                 empty_o
    );

import common::*;
import cpu_common::*;

word_t raw_w;
word_t shifted_w;

always_comb begin
    raw_w = load_i ? dmem_read_data_i : wb_data_i;

    // bring the addressed byte down to lane 0
    case (ma_alignment_i)
        2'b00: shifted_w = raw_w;
        2'b01: shifted_w = {8'b0, raw_w[31:8]};
        2'b10: shifted_w = {16'b0, raw_w[31:16]};
        2'b11: shifted_w = {24'b0, raw_w[31:24]};
    endcase

    case (ma_size_i)
        MA_SIZE_B:  wb_data_o = {{24{shifted_w[7]}}, shifted_w[7:0]};
        MA_SIZE_H:  wb_data_o = {{16{shifted_w[15]}}, shifted_w[15:0]};
        MA_SIZE_BU: wb_data_o = {24'b0, shifted_w[7:0]};
        MA_SIZE_HU: wb_data_o = {16'b0, shifted_w[15:0]};
        default:    wb_data_o = shifted_w;  // word
    endcase

    wb_addr_o  = ir_i[11:7];    // rd
    wb_valid_o = wb_valid_i;
    empty_o    = (pc_i == NOP_PC);
end

endmodule

// File: verilog/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile (
        input  logic             clk_i,
        input  logic             we_i,
        input  common::regaddr_t waddr_i,
        input  common::regaddr_t raddr_i,   // observation port
        input  common::word_t    wdata_i,
        output common::word_t    rdata_o
    );

import common::*;

word_t regs [NUM_REGS];

always_ff @(posedge clk_i) begin
    if (we_i && (waddr_i != '0)) begin   // x0 stays zero
        regs[waddr_i] <= wdata_i;
    end
end

// no bypass, a write shows after the edge
assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// File: verilog/cpu_mem_wb.sv
`timescale 1ns/1ps

module cpu_mem_wb (
        input  logic             clk_i,
        input  logic             rst_i,
        input  logic             issue_i,
        input  common::word_t    pc_i,
        input  common::word_t    ir_i,
        input  common::word_t    addr_i,
        input  common::word_t    store_data_i,
        input  common::word_t    alu_result_i,
        input  common::regaddr_t rs_addr_i,
        output common::word_t    rs_data_o,
        output logic             wb_valid_o,
        output logic             empty_o,
        output common::regaddr_t wb_addr_o,
        output common::word_t    wb_data_o
    );

import common::*;
import cpu_common::*;

// memory stage to data memory
word_t      dmem_addr;
word_t      dmem_wdata;
logic [3:0] dmem_we;
word_t      dmem_rdata;

// write-back register
word_t      wb_pc;
word_t      wb_ir;
word_t      wb_alu_data;
logic       wb_load;
logic       wb_en;
ma_size_t   wb_ma_size;
logic [1:0] wb_align;

cpu_mem_ctrl cpu_mem_ctrl_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_i       (issue_i),
    .pc_i          (pc_i),
    .ir_i          (ir_i),
    .addr_i        (addr_i),
    .store_data_i  (store_data_i),
    .alu_result_i  (alu_result_i),
    .dmem_addr_o   (dmem_addr),
    .dmem_wdata_o  (dmem_wdata),
    .dmem_we_o     (dmem_we),
    .wb_pc_o       (wb_pc),
    .wb_ir_o       (wb_ir),
    .wb_alu_data_o (wb_alu_data),
    .wb_load_o     (wb_load),
    .wb_en_o       (wb_en),
    .wb_ma_size_o  (wb_ma_size),
    .wb_align_o    (wb_align)
);

cpu_dmem cpu_dmem_i (
    .clk_i   (clk_i),
    .addr_i  (dmem_addr),
    .wdata_i (dmem_wdata),
    .we_i    (dmem_we),
    .rdata_o (dmem_rdata)
);

cpu_wb cpu_wb_i (
    .dmem_read_data_i (dmem_rdata),
    .pc_i             (wb_pc),
    .ir_i             (wb_ir),
    .wb_data_i        (wb_alu_data),
    .load_i           (wb_load),
    .wb_valid_i       (wb_en),
    .ma_size_i        (wb_ma_size),
    .ma_alignment_i   (wb_align),
    .wb_addr_o        (wb_addr_o),
    .wb_data_o        (wb_data_o),
    .wb_valid_o       (wb_valid_o),
    .empty_o          (empty_o)
);

// written at the edge after write-back
cpu_regfile cpu_regfile_i (
    .clk_i   (clk_i),
    .we_i    (wb_valid_o),
    .waddr_i (wb_addr_o),
    .raddr_i (rs_addr_i),
    .wdata_i (wb_data_o),
    .rdata_o (rs_data_o)
);

endmodule

// File: tests/cpu_mem_wb_asserts.sv
`timescale 1ns/1ps

module cpu_mem_wb_asserts (
        input logic       clk_i,
        input logic       rst_i,
        input logic       issue_i,
        input logic [3:0] dmem_we_i,    // byte lanes from the memory stage
        input logic       wb_valid_i,
        input logic       empty_i
    );

// failures seen so far, one counter per property
int viol_empty_cnt = 0;
int viol_reset_cnt = 0;
int viol_issue_cnt = 0;

// a bubble never writes the register file
empty_not_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    empty_i |-> !wb_valid_i)
    else begin
        viol_empty_cnt++;
        $error("write-back valid while the stage is empty");
    end

reset_no_store: assert property (@(posedge clk_i) rst_i |=> (dmem_we_i == 4'b0000))
    else begin
        viol_reset_cnt++;
        $error("data memory write enabled right after a reset cycle");
    end

// fixed two-edge latency to write-back
issue_reaches_wb: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_i |-> ##2 !empty_i)
    else begin
        viol_issue_cnt++;
        $error("issued instruction missing from write-back two edges later");
    end

endmodule

bind cpu_mem_wb cpu_mem_wb_asserts cpu_mem_wb_asserts_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_i),
    .dmem_we_i  (dmem_we),
    .wb_valid_i (wb_valid_o),
    .empty_i    (empty_o)
);

// File: tests/tb_cpu_mem_wb.sv
`timescale 1ns/1ps

module tb_cpu_mem_wb;

import common::*;
import cpu_common::*;

localparam int         RESET_CYCLES = 8;
localparam logic [6:0] OPC_BRANCH   = 7'b110_0011;   // retires without a register write

logic     clk_i = 1'b0;
logic     rst_i, issue_i;
word_t    pc_i, ir_i, addr_i, store_data_i, alu_result_i;
regaddr_t rs_addr_i;
word_t    rs_data_o, wb_data_o;
logic     wb_valid_o, empty_o;
regaddr_t wb_addr_o;

// stimulus table, one index per row
string      row_name[$];
logic [6:0] row_opc[$];
regaddr_t   row_rd[$];
logic [2:0] row_f3[$];
word_t      row_addr[$], row_sdata[$], row_alu[$], row_exp_data[$];
logic       row_exp_valid[$];

int pend_row_q[$];  // rows in flight
int pend_due_q[$];  // cycle each one must show on the write-back port

word_t       reg_model [32];
logic        reg_written [32];
logic [16:0] lfsr_state;
int          cycle_cnt = 0;
int          cycle_limit = 0;
int          err_cnt = 0;
int          test_cnt = 0;
int          fail_cnt = 0;
int          back_to_back = 0;
logic        prev_issued = 1'b0;
int          errs_before;

cpu_mem_wb cpu_mem_wb_i (.*);

always #2 clk_i = ~clk_i;

// x^17 + x^14 + 1
function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
endfunction

task automatic add_row(input string name, input logic [6:0] opc, input int rd, input int f3,
        input word_t addr, input word_t sdata, input word_t alu, input logic ev, input word_t ed);
    row_name.push_back(name);
    row_opc.push_back(opc);
    row_rd.push_back(regaddr_t'(rd));
    row_f3.push_back(3'(f3));
    row_addr.push_back(addr);
    row_sdata.push_back(sdata);
    row_alu.push_back(alu);
    row_exp_valid.push_back(ev);
    row_exp_data.push_back(ed);
    if (ev) begin   // last retired value wins, x0 stays zero
        reg_written[rd] = 1'b1;
        reg_model[rd]   = (rd == 0) ? '0 : ed;
    end
endtask

task automatic close_test(input string name, input int errs_at_start);
    test_cnt++;
    if (err_cnt == errs_at_start) begin
        $display("%s: ok", name);
    end else begin
        fail_cnt++;
        $display("%s: failed", name);
    end
endtask

// called on every falling edge
task automatic check_outputs();
    int idx;
    int errs_at_start;
    if (pend_due_q.size() > 0 && pend_due_q[0] == cycle_cnt) begin
        idx           = pend_row_q.pop_front();
        errs_at_start = err_cnt;
        void'(pend_due_q.pop_front());
        assert (!empty_o) else begin
            $display("[ERROR] %s: empty_o expected 0, actual %b", row_name[idx], empty_o);
            err_cnt++;
        end
        assert (wb_valid_o == row_exp_valid[idx]) else begin
            $display("[ERROR] %s: wb_valid_o expected %b, actual %b", row_name[idx],
                     row_exp_valid[idx], wb_valid_o);
            err_cnt++;
        end
        if (row_exp_valid[idx]) begin   // addr and data only matter on a write
            assert (wb_addr_o == row_rd[idx]) else begin
                $display("[ERROR] %s: wb_addr_o expected %0d, actual %0d", row_name[idx],
                         row_rd[idx], wb_addr_o);
                err_cnt++;
            end
            assert (wb_data_o == row_exp_data[idx]) else begin
                $display("[ERROR] %s: wb_data_o expected %h, actual %h", row_name[idx],
                         row_exp_data[idx], wb_data_o);
                err_cnt++;
            end
        end
        close_test(row_name[idx], errs_at_start);
    end else begin
        assert (empty_o && !wb_valid_o) else begin
            $display("write-back stage busy at cycle %0d with nothing due", cycle_cnt);
            err_cnt++;
        end
    end
endtask

task automatic next_cycle();
    @(negedge clk_i);
    check_outputs();
endtask

task automatic drive_row(input int i);
    issue_i      = 1'b1;
    pc_i         = 32'h0000_0100 + 32'(4 * i);
    ir_i         = {17'b0, row_f3[i], row_rd[i], row_opc[i]};
    addr_i       = row_addr[i];
    store_data_i = row_sdata[i];
    alu_result_i = row_alu[i];
    pend_row_q.push_back(i);
    pend_due_q.push_back(cycle_cnt + 2);  // sampled next edge, write-back one edge later
    if (prev_issued) begin
        back_to_back++;
    end
    prev_issued = 1'b1;
endtask

initial begin
    rst_i        = 1'b1;
    issue_i      = 1'b0;
    pc_i         = NOP_PC;
    ir_i         = '0;
    addr_i       = '0;
    store_data_i = '0;
    alu_result_i = '0;
    rs_addr_i    = '0;
    lfsr_state   = 17'd96029;
    for (int r = 0; r < 32; r++) begin
        reg_written[r] = 1'b0;
        reg_model[r]   = '0;
    end

    //      name          opcode      rd f3 addr    store data     alu result  valid data
    add_row("add_x1",     OPC_OP,     1, 0, 32'h0,  32'h0,         32'h1234_5678, 1, 32'h1234_5678);
    add_row("lui_x2",     OPC_LUI,    2, 0, 32'h0,  32'h0,         32'habcd_e000, 1, 32'habcd_e000);
    add_row("addi_x0",    OPC_OP_IMM, 0, 0, 32'h0,  32'h0,         32'hdead_beef, 1, 32'hdead_beef);
    add_row("jal_x3",     OPC_JAL,    3, 0, 32'h0,  32'h0,         32'h0000_0104, 1, 32'h0000_0104);
    add_row("beq",        OPC_BRANCH, 0, 0, 32'h0,  32'h0,         32'h0000_0055, 0, 32'h0);
    add_row("sw_10",      OPC_STORE,  0, 2, 32'h10, 32'h1122_3344, 32'h0, 0, 32'h0);
    add_row("sw_20",      OPC_STORE,  0, 2, 32'h20, 32'ha5a5_a5a5, 32'h0, 0, 32'h0);
    add_row("sw_30",      OPC_STORE,  0, 2, 32'h30, 32'h8081_7f70, 32'h0, 0, 32'h0);
    add_row("sb_21",      OPC_STORE,  0, 0, 32'h21, 32'hffff_ff3c, 32'h0, 0, 32'h0);
    add_row("sh_22",      OPC_STORE,  0, 1, 32'h22, 32'h1234_beef, 32'h0, 0, 32'h0);
    add_row("sh_10",      OPC_STORE,  0, 1, 32'h10, 32'h0000_cafe, 32'h0, 0, 32'h0);
    add_row("sb_13",      OPC_STORE,  0, 0, 32'h13, 32'h0000_0099, 32'h0, 0, 32'h0);
    add_row("lw_x4_10",   OPC_LOAD,   4, 2, 32'h10, 32'h0, 32'h0, 1, 32'h9922_cafe);
    add_row("lw_x5_20",   OPC_LOAD,   5, 2, 32'h20, 32'h0, 32'h0, 1, 32'hbeef_3ca5);
    add_row("lb_x6_30",   OPC_LOAD,   6, 0, 32'h30, 32'h0, 32'h0, 1, 32'h0000_0070);
    add_row("lb_x7_31",   OPC_LOAD,   7, 0, 32'h31, 32'h0, 32'h0, 1, 32'h0000_007f);
    add_row("lb_x8_32",   OPC_LOAD,   8, 0, 32'h32, 32'h0, 32'h0, 1, 32'hffff_ff81);
    add_row("lb_x9_33",   OPC_LOAD,   9, 0, 32'h33, 32'h0, 32'h0, 1, 32'hffff_ff80);
    add_row("lbu_x10_32", OPC_LOAD,  10, 4, 32'h32, 32'h0, 32'h0, 1, 32'h0000_0081);
    add_row("lbu_x11_33", OPC_LOAD,  11, 4, 32'h33, 32'h0, 32'h0, 1, 32'h0000_0080);
    add_row("lh_x12_30",  OPC_LOAD,  12, 1, 32'h30, 32'h0, 32'h0, 1, 32'h0000_7f70);
    add_row("lh_x13_32",  OPC_LOAD,  13, 1, 32'h32, 32'h0, 32'h0, 1, 32'hffff_8081);
    add_row("lhu_x14_32", OPC_LOAD,  14, 5, 32'h32, 32'h0, 32'h0, 1, 32'h0000_8081);
    add_row("lhu_x15_30", OPC_LOAD,  15, 5, 32'h30, 32'h0, 32'h0, 1, 32'h0000_7f70);
    add_row("lbu_x16_21", OPC_LOAD,  16, 4, 32'h21, 32'h0, 32'h0, 1, 32'h0000_003c);
    add_row("lh_x17_22",  OPC_LOAD,  17, 1, 32'h22, 32'h0, 32'h0, 1, 32'hffff_beef);
    add_row("lb_x18_10",  OPC_LOAD,  18, 0, 32'h10, 32'h0, 32'h0, 1, 32'hffff_fffe);
    add_row("lbu_x19_30", OPC_LOAD,  19, 4, 32'h30, 32'h0, 32'h0, 1, 32'h0000_0070);
    add_row("auipc_x20",  OPC_AUIPC, 20, 0, 32'h0,  32'h0, 32'h0000_1100, 1, 32'h0000_1100);
    add_row("add_x1b",    OPC_OP,     1, 0, 32'h0,  32'h0, 32'h0f0f_0f0f, 1, 32'h0f0f_0f0f);
    cycle_limit = 3 * row_name.size() + RESET_CYCLES + 20;

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;

    // bubbles only, nothing issued yet
    errs_before = err_cnt;
    repeat (3) next_cycle();
    close_test("reset_idle", errs_before);

    for (int i = 0; i < row_name.size(); i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        if (lfsr_state[0]) begin    // one idle cycle before this row
            issue_i     = 1'b0;
            prev_issued = 1'b0;
            next_cycle();
        end
        drive_row(i);
        next_cycle();
    end
    issue_i = 1'b0;
    while (pend_row_q.size() > 0) begin
        next_cycle();
    end
    next_cycle();   // last write lands in the register file

    for (int r = 0; r < 32; r++) begin
        if (reg_written[r]) begin
            errs_before = err_cnt;
            rs_addr_i   = regaddr_t'(r);
            next_cycle();
            assert (rs_data_o == reg_model[r]) else begin
                $display("[ERROR] reg_x%0d: rs_data_o expected %h, actual %h", r,
                         reg_model[r], rs_data_o);
                err_cnt++;
            end
            close_test($sformatf("reg_x%0d", r), errs_before);
        end
    end

    assert (back_to_back > 0) else begin
        $display("no two rows were issued back to back");
        err_cnt++;
    end
    assert (cpu_mem_wb_i.cpu_mem_wb_asserts_i.viol_empty_cnt
            + cpu_mem_wb_i.cpu_mem_wb_asserts_i.viol_reset_cnt
            + cpu_mem_wb_i.cpu_mem_wb_asserts_i.viol_issue_cnt == 0) else begin
        $display("pipeline protocol assertions failed during the run");
        err_cnt++;
    end

    $display("tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
        $display("timeout, run went past %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end
end

endmodule

// File: cpu_mem_wb.f
verilog/common_pkg.sv
verilog/cpu_common_pkg.sv
verilog/cpu_mem_ctrl.sv
verilog/cpu_dmem.sv
verilog/cpu_wb.sv
verilog/cpu_regfile.sv
verilog/cpu_mem_wb.sv
tests/cpu_mem_wb_asserts.sv
tests/tb_cpu_mem_wb.sv

// File: Makefile
TOP := tb_cpu_mem_wb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f cpu_mem_wb.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then \
		echo "test failed"; \
		exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log
